/* bench/m_ext_unit_sva.sv */
// Muldiv protocol assertions
`timescale 1ns/100ps
`include "m_ext_macros.svh"

module m_ext_unit_sva (
    input logic             clk,
    input logic             rst_n,
    input logic             valid_i,
    input logic             ready_i,
    input logic             stall_i,
    input logic             flush_i,
    input logic             req_i,
    input logic             ack_i,
    input logic [`XLEN-1:0] result_i,
    input logic             div_busy_i,
    input logic             div_done_i
);

    // one op in flight at a time
    accept_holds_op: assert property (@(posedge clk) disable iff (!rst_n)
        (valid_i && ready_i && !flush_i) |=> (req_i && !ready_i))
        else $error("accepted op not held or ready still high");

    ack_needs_op: assert property (@(posedge clk) disable iff (!rst_n)
        ack_i |-> req_i) else $error("ack high without a held op");

    // presented result frozen by stall
    stall_holds_result: assert property (@(posedge clk) disable iff (!rst_n)
        (ack_i && stall_i && !flush_i) |=> (ack_i && $stable(result_i)))
        else $error("result or ack changed under stall");

    // done pulse right after XLEN+1 busy cycles
    divide_run_length: assert property (@(posedge clk) disable iff (!rst_n || flush_i)
        $rose(div_busy_i) |-> div_busy_i [*(`XLEN+1)] ##1 (!div_busy_i && div_done_i))
        else $error("divider done not at the end of its busy run");

endmodule

bind muldiv m_ext_unit_sva m_ext_unit_sva_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .valid_i    (exe2mul_valid_i),
    .ready_i    (exe2mul_ready_o),
    .stall_i    (fwd2mul_stall_i),
    .flush_i    (fwd2mul_flush_i),
    .req_i      (mul2fwd_o.mul_req),
    .ack_i      (mul2fwd_o.mul_ack),
    .result_i   (mul2wrb_o.alu_m_result),
    .div_busy_i (div_busy),
    .div_done_i (div_done)
);

/* bench/tb_m_ext_unit.sv */
// M extension unit testbench
`timescale 1ns/100ps
`include "m_ext_macros.svh"

module tb_m_ext_unit;

    localparam int MAX_STALL = 3;
    localparam int NUM_FIXED = 22;
    localparam int NUM_RAND  = 40;
    localparam int NUM_ROWS  = NUM_FIXED + NUM_RAND;

    typedef struct packed {
        m_ext_pkg::alu_m_ops_e op;
        m_ext_pkg::word_t      opr1;
        m_ext_pkg::word_t      opr2;
        m_ext_pkg::word_t      expected;
        logic [1:0]            stall;  // cycles held while the result is presented
        logic                  flush;  // aborted after acceptance, never acked
    } row_s;

    // op, operand 1, operand 2, expected, stall cycles, flush
    row_s fixed_rows [NUM_FIXED] = '{
        '{m_ext_pkg::ALU_M_OPS_MUL,    'h7,        'hfffffffd, 'hffffffeb, 0, 0},
        '{m_ext_pkg::ALU_M_OPS_MUL,    'h80000000, 'hffffffff, 'h80000000, 1, 0},
        '{m_ext_pkg::ALU_M_OPS_MULH,   'h80000000, 'h80000000, 'h40000000, 0, 0},
        '{m_ext_pkg::ALU_M_OPS_MULH,   'h80000000, 'h2,        'hffffffff, 3, 0},
        '{m_ext_pkg::ALU_M_OPS_MULHSU, 'hffffffff, 'hffffffff, 'hffffffff, 0, 0},
        '{m_ext_pkg::ALU_M_OPS_MULHSU, 'h80000000, 'hffffffff, 'h80000000, 2, 0},
        '{m_ext_pkg::ALU_M_OPS_MULHU,  'hffffffff, 'hffffffff, 'hfffffffe, 0, 0},
        '{m_ext_pkg::ALU_M_OPS_DIV,    'hffffffec, 'h3,        'hfffffffa, 0, 0},
        '{m_ext_pkg::ALU_M_OPS_DIV,    'h14,       'hfffffffd, 'hfffffffa, 0, 0},
        '{m_ext_pkg::ALU_M_OPS_DIV,    'hffffffec, 'hfffffffd, 'h6,        1, 0},
        '{m_ext_pkg::ALU_M_OPS_REM,    'hffffffec, 'h3,        'hfffffffe, 2, 0},
        '{m_ext_pkg::ALU_M_OPS_REM,    'h14,       'hfffffffd, 'h2,        0, 0},
        '{m_ext_pkg::ALU_M_OPS_DIVU,   'hffffffec, 'h3,        'h5555554e, 0, 0},
        '{m_ext_pkg::ALU_M_OPS_REMU,   'hffffffec, 'h3,        'h2,        0, 0},
        '{m_ext_pkg::ALU_M_OPS_DIV,    'h4d2,      'h0,        'hffffffff, 0, 0},
        '{m_ext_pkg::ALU_M_OPS_DIVU,   'h5,        'h0,        'hffffffff, 1, 0},
        '{m_ext_pkg::ALU_M_OPS_REM,    'hdeadbeef, 'h0,        'hdeadbeef, 0, 0},
        '{m_ext_pkg::ALU_M_OPS_REMU,   'h1234,     'h0,        'h1234,     0, 0},
        '{m_ext_pkg::ALU_M_OPS_DIV,    'h80000000, 'hffffffff, 'h80000000, 3, 0},
        '{m_ext_pkg::ALU_M_OPS_REM,    'h80000000, 'hffffffff, 'h0,        0, 0},
        '{m_ext_pkg::ALU_M_OPS_DIV,    'h64,       'h7,        'h0,        0, 1},
        '{m_ext_pkg::ALU_M_OPS_DIVU,   'h3e8,      'h9,        'h6f,       0, 0}
    };

    m_ext_pkg::alu_m_ops_e op_list [8] = '{
        m_ext_pkg::ALU_M_OPS_MUL, m_ext_pkg::ALU_M_OPS_MULH,
        m_ext_pkg::ALU_M_OPS_MULHSU, m_ext_pkg::ALU_M_OPS_MULHU,
        m_ext_pkg::ALU_M_OPS_DIV, m_ext_pkg::ALU_M_OPS_DIVU,
        m_ext_pkg::ALU_M_OPS_REM, m_ext_pkg::ALU_M_OPS_REMU
    };

    logic                    clk;
    logic                    rst_n;
    pipe_pkg::type_exe2mul_s exe2mul;
    logic                    exe2mul_valid;
    logic                    exe2mul_ready;
    pipe_pkg::type_fwd2mul_s fwd2mul;
    pipe_pkg::type_mul2fwd_s mul2fwd;
    pipe_pkg::type_mul2wrb_s mul2wrb;
    logic [31:0]             lfsr_q   = 32'd48;
    int                      ack_cnt  = 0;
    int                      exp_acks = 0;

    m_ext_unit m_ext_unit_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .exe2mul_i       (exe2mul),
        .exe2mul_valid_i (exe2mul_valid),
        .exe2mul_ready_o (exe2mul_ready),
        .fwd2mul_i       (fwd2mul),
        .mul2fwd_o       (mul2fwd),
        .mul2wrb_o       (mul2wrb)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v      = {v[30:0], lfsr_q[0]};
        end
    endtask

    // RISC-V M rules, division truncates toward zero
    function automatic m_ext_pkg::word_t ref_result(input m_ext_pkg::alu_m_ops_e op,
                                                    input m_ext_pkg::word_t a,
                                                    input m_ext_pkg::word_t b);
        logic [2*`XLEN-1:0] ss;
        logic [2*`XLEN-1:0] su;
        logic [2*`XLEN-1:0] uu;
        m_ext_pkg::word_t   sq;
        m_ext_pkg::word_t   sr;
        logic               zero;
        logic               ovf;
        ss   = {{`XLEN{a[`XLEN-1]}}, a} * {{`XLEN{b[`XLEN-1]}}, b};
        su   = {{`XLEN{a[`XLEN-1]}}, a} * {{`XLEN{1'b0}}, b};
        uu   = {{`XLEN{1'b0}}, a} * {{`XLEN{1'b0}}, b};
        sq   = $signed(a) / $signed(b);
        sr   = $signed(a) % $signed(b);
        zero = (b == '0);
        ovf  = (a == {1'b1, {(`XLEN-1){1'b0}}}) && (b == '1);  // most negative by -1
        case (op)
            m_ext_pkg::ALU_M_OPS_MUL:    return ss[`XLEN-1:0];
            m_ext_pkg::ALU_M_OPS_MULH:   return ss[2*`XLEN-1:`XLEN];
            m_ext_pkg::ALU_M_OPS_MULHSU: return su[2*`XLEN-1:`XLEN];
            m_ext_pkg::ALU_M_OPS_MULHU:  return uu[2*`XLEN-1:`XLEN];
            m_ext_pkg::ALU_M_OPS_DIV:    return zero ? '1 : (ovf ? a : sq);
            m_ext_pkg::ALU_M_OPS_DIVU:   return zero ? '1 : a / b;
            m_ext_pkg::ALU_M_OPS_REM:    return zero ? a : (ovf ? '0 : sr);
            m_ext_pkg::ALU_M_OPS_REMU:   return zero ? a : a % b;
            default:                     return '0;
        endcase
    endfunction

    task automatic compare_word(input string name, input m_ext_pkg::word_t exp,
                                input m_ext_pkg::word_t act);
        assert (act === exp) else begin
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
            $display("** FAIL **");
            $fatal(1, "value mismatch");
        end
    endtask

    // starts and ends 2 ns after a rising edge, samples 1 ns after it
    task automatic run_row(input int idx, input row_s r);
        string name;
        name = $sformatf("row %0d %s", idx, r.op.name());
        compare_word({name, " ready idle"}, 1, exe2mul_ready);
        exe2mul.alu_m_ops.op  = r.op;
        exe2mul.alu_operand_1 = r.opr1;
        exe2mul.alu_operand_2 = r.opr2;
        exe2mul_valid         = 1'b1;
        do begin
            @(posedge clk);
            #1;
        end while (!mul2fwd.mul_req);  // held from acceptance on
        compare_word({name, " ready while held"}, 0, exe2mul_ready);
        #1;
        exe2mul_valid = 1'b0;
        if (r.flush) begin
            repeat (4) @(posedge clk);
            #2;
            fwd2mul.flush = 1'b1;  // divider mid run
            @(posedge clk);
            #2;
            fwd2mul.flush = 1'b0;
            repeat (`XLEN + 4) begin
                @(posedge clk);
                #1;
                compare_word({name, " flushed req/ack"}, '0, {mul2fwd.mul_req, mul2fwd.mul_ack});
            end
        end else begin
            do begin
                @(posedge clk);
                #1;
            end while (!mul2fwd.mul_ack);
            compare_word(name, r.expected, mul2wrb.alu_m_result);
            if (r.stall != 0) begin
                #1;
                fwd2mul.stall = 1'b1;
                repeat (r.stall) begin
                    @(posedge clk);
                    #1;
                    compare_word({name, " stalled ack"}, 1, mul2fwd.mul_ack);
                    compare_word({name, " stalled"}, r.expected, mul2wrb.alu_m_result);
                end
                #1;
                fwd2mul.stall = 1'b0;
                #1;
                compare_word({name, " released"}, r.expected, mul2wrb.alu_m_result);
            end
            @(posedge clk);
            #1;
            compare_word({name, " retired req/ack"}, '0, {mul2fwd.mul_req, mul2fwd.mul_ack});
        end
        #1;
    endtask

    // each edge with ack high and stall low retires one result
    always @(posedge clk) begin
        if (rst_n && mul2fwd.mul_ack && !fwd2mul.stall) begin
            ack_cnt++;
        end
    end

    initial begin
        repeat (NUM_ROWS * (`XLEN + 3 + MAX_STALL) + 100) @(posedge clk);
        $display("watchdog expired, the unit stopped answering requests");
        $display("** FAIL **");
        $fatal(1, "timeout");
    end

    initial begin
        logic [31:0] sel;
        logic [31:0] opr1;
        logic [31:0] opr2;
        logic [31:0] st;
        row_s        r;
        rst_n         = 1'b0;
        exe2mul       = '0;
        exe2mul_valid = 1'b0;
        fwd2mul       = '0;
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (i < NUM_FIXED) begin
                r = fixed_rows[i];
            end else begin
                take_bits(3, sel);
                take_bits(`XLEN, opr1);
                take_bits(`XLEN, opr2);
                take_bits(2, st);
                r = '{op_list[sel[2:0]], opr1, opr2,
                      ref_result(op_list[sel[2:0]], opr1, opr2), st[1:0], 1'b0};
            end
            exp_acks += r.flush ? 0 : 1;
            run_row(i, r);
        end
        @(posedge clk);
        #1;
        if (ack_cnt == exp_acks) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("[ERROR] ack count expected %0d actual %0d", exp_acks, ack_cnt);
            $display("** FAIL **");
            $fatal(1, "ack count mismatch");
        end
    end

endmodule

/* design/divider.sv */
// Iterative restoring divider
`timescale 1ns/100ps
`include "m_ext_macros.svh"

module divider (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start_i,
    input  logic             abort_i,
    input  logic [`XLEN-1:0] opr1_i,   // dividend
    input  logic [`XLEN-1:0] opr2_i,   // divisor
    output logic             busy_o,
    output logic             done_o,
    output logic [`XLEN-1:0] quo_o,
    output logic [`XLEN-1:0] rem_o
);

    logic                  busy_q;
    logic                  done_q;
    logic [`DIV_CNT_W-1:0] cnt_q;
    logic [`XLEN-1:0]      quo_q;   // dividend bits shift out, quotient bits in
    logic [`XLEN-1:0]      rem_q;
    logic [`XLEN-1:0]      dvs_q;
    logic [`XLEN:0]        trial;
    logic                  fits;
    logic                  last_step;

    assign last_step = (cnt_q == `DIV_CNT_W'(`XLEN));

    // next dividend bit into the partial remainder
    assign trial = {rem_q, quo_q[`XLEN-1]};
    assign fits  = (trial >= {1'b0, dvs_q});  // always true for a zero divisor

    always_ff @(posedge clk) begin
        if (!rst_n || abort_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else begin
            done_q <= 1'b0;
            if (start_i) begin
                busy_q <= 1'b1;
                cnt_q  <= '0;
            end else if (busy_q) begin
                if (last_step) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end else begin
                    cnt_q <= cnt_q + 1'b1;
                end
            end
        end
    end

    // one quotient bit per step
    always_ff @(posedge clk) begin
        if (start_i) begin
            rem_q <= '0;
            quo_q <= opr1_i;
            dvs_q <= opr2_i;
        end else if (busy_q && !last_step) begin
            rem_q <= fits ? (trial[`XLEN-1:0] - dvs_q) : trial[`XLEN-1:0];  // restore
            quo_q <= {quo_q[`XLEN-2:0], fits};
        end
    end

    assign busy_o = busy_q;
    assign done_o = done_q;
    assign quo_o  = quo_q;   // held until the next start
    assign rem_o  = rem_q;

endmodule

/* design/m_ext_macros.svh */
// M extension width macros
`ifndef M_EXT_MACROS_SVH
`define M_EXT_MACROS_SVH

// data word width
`define XLEN 32

// divider step counter, has to reach XLEN
`define DIV_CNT_W 6

`endif

/* design/m_ext_pkg.sv */
// M extension operations and types
`include "m_ext_macros.svh"

package m_ext_pkg;

    // single data word and full product
    typedef logic [`XLEN-1:0]   word_t;
    typedef logic [2*`XLEN-1:0] dword_t;

    // top bit set selects the divider
    typedef enum logic [3:0] {
        ALU_M_OPS_NONE   = 4'h0,
        ALU_M_OPS_MUL    = 4'h1,
        ALU_M_OPS_MULH   = 4'h2,
        ALU_M_OPS_MULHSU = 4'h3,
        ALU_M_OPS_MULHU  = 4'h4,
        ALU_M_OPS_DIV    = 4'h8,
        ALU_M_OPS_DIVU   = 4'h9,
        ALU_M_OPS_REM    = 4'hA,
        ALU_M_OPS_REMU   = 4'hB
    } alu_m_ops_e;

    // field view of the same op word
    typedef struct packed {
        logic       is_div;   // divider class
        logic [2:0] variant;  // bit 0 unsigned, bit 1 remainder (divides)
    } alu_m_op_fields_s;

    typedef union packed {
        alu_m_ops_e       op;
        alu_m_op_fields_s f;
    } alu_m_op_u;

endpackage

/* design/m_ext_unit.sv */
// M extension unit top level
`timescale 1ns/100ps

module m_ext_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  pipe_pkg::type_exe2mul_s exe2mul_i,
    input  logic                    exe2mul_valid_i,
    output logic                    exe2mul_ready_o,
    input  pipe_pkg::type_fwd2mul_s fwd2mul_i,
    output pipe_pkg::type_mul2fwd_s mul2fwd_o,
    output pipe_pkg::type_mul2wrb_s mul2wrb_o
);

    logic fwd_stall;
    logic fwd_flush;

    // hazard controls as single wires
    assign fwd_stall = fwd2mul_i.stall;
    assign fwd_flush = fwd2mul_i.flush;

    muldiv muldiv_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .exe2mul_i       (exe2mul_i),
        .exe2mul_valid_i (exe2mul_valid_i),
        .exe2mul_ready_o (exe2mul_ready_o),
        .fwd2mul_stall_i (fwd_stall),
        .fwd2mul_flush_i (fwd_flush),
        .mul2fwd_o       (mul2fwd_o),
        .mul2wrb_o       (mul2wrb_o)
    );

endmodule

/* design/muldiv.sv */
// Multiply and divide unit
`timescale 1ns/100ps
`include "m_ext_macros.svh"

module muldiv (
    input  logic                    clk,
    input  logic                    rst_n,
    input  pipe_pkg::type_exe2mul_s exe2mul_i,
    input  logic                    exe2mul_valid_i,
    output logic                    exe2mul_ready_o,
    input  logic                    fwd2mul_stall_i,
    input  logic                    fwd2mul_flush_i,
    output pipe_pkg::type_mul2fwd_s mul2fwd_o,
    output pipe_pkg::type_mul2wrb_s mul2wrb_o
);

    m_ext_pkg::alu_m_op_u in_op;
    m_ext_pkg::alu_m_op_u op_q;
    m_ext_pkg::word_t     in_opr1;
    m_ext_pkg::word_t     in_opr2;
    m_ext_pkg::word_t     opr1_q;
    m_ext_pkg::word_t     opr2_q;
    logic                 sign1_q;
    logic                 sign2_q;
    logic                 in_sdiv;
    logic                 held;
    logic                 accept;
    logic                 retire;
    logic                 res_ready;
    logic                 ack_set;
    logic                 ack_q;
    m_ext_pkg::word_t     result_d;
    m_ext_pkg::word_t     result_q;
    m_ext_pkg::dword_t    prod_uu;
    m_ext_pkg::dword_t    prod_ss;
    m_ext_pkg::dword_t    prod_su;
    logic                 div_start;
    logic                 div_busy;
    logic                 div_done;
    logic                 div_fin_q;
    m_ext_pkg::word_t     div_quo;
    m_ext_pkg::word_t     div_rem;

    assign in_op   = exe2mul_i.alu_m_ops;
    assign in_sdiv = in_op.f.is_div && !in_op.f.variant[0];  // DIV or REM

    // magnitudes for the signed divides and the signed half of MULHSU
    assign in_opr1 = ((in_sdiv || in_op.op == m_ext_pkg::ALU_M_OPS_MULHSU) &&
                      exe2mul_i.alu_operand_1[`XLEN-1]) ?
                     -exe2mul_i.alu_operand_1 : exe2mul_i.alu_operand_1;
    assign in_opr2 = (in_sdiv && exe2mul_i.alu_operand_2[`XLEN-1]) ?
                     -exe2mul_i.alu_operand_2 : exe2mul_i.alu_operand_2;

    assign held            = (op_q.op != m_ext_pkg::ALU_M_OPS_NONE);
    assign exe2mul_ready_o = !held && !fwd2mul_stall_i;
    assign accept          = exe2mul_valid_i && exe2mul_ready_o && !fwd2mul_flush_i;
    assign retire          = ack_q && !fwd2mul_stall_i;

    // multiplies are ready right away, divides once done was seen
    assign res_ready = !op_q.f.is_div || div_done || div_fin_q;
    assign ack_set   = held && !ack_q && res_ready && !fwd2mul_stall_i && !fwd2mul_flush_i;

    assign div_start = held && op_q.f.is_div && !div_busy && !div_done && !div_fin_q &&
                       !fwd2mul_stall_i && !fwd2mul_flush_i;

    always_ff @(posedge clk) begin
        if (!rst_n || fwd2mul_flush_i) begin
            op_q      <= '0;
            ack_q     <= 1'b0;
            div_fin_q <= 1'b0;
        end else begin
            if (div_done) begin
                div_fin_q <= 1'b1;  // kept through a stall
            end
            if (retire) begin
                op_q      <= '0;
                ack_q     <= 1'b0;
                div_fin_q <= 1'b0;
            end else if (accept) begin
                op_q <= in_op;
            end
            if (ack_set) begin
                ack_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            opr1_q  <= in_opr1;
            opr2_q  <= in_opr2;
            sign1_q <= exe2mul_i.alu_operand_1[`XLEN-1];  // original signs
            sign2_q <= exe2mul_i.alu_operand_2[`XLEN-1];
        end
        if (ack_set) begin
            result_q <= result_d;
        end
    end

    assign prod_uu = opr1_q * opr2_q;
    assign prod_ss = $signed(opr1_q) * $signed(opr2_q);
    assign prod_su = sign1_q ? -prod_uu : prod_uu;

    always_comb begin
        case (op_q.op)
            m_ext_pkg::ALU_M_OPS_MUL:    result_d = prod_ss[`XLEN-1:0];
            m_ext_pkg::ALU_M_OPS_MULH:   result_d = prod_ss[2*`XLEN-1:`XLEN];
            m_ext_pkg::ALU_M_OPS_MULHSU: result_d = prod_su[2*`XLEN-1:`XLEN];
            m_ext_pkg::ALU_M_OPS_MULHU:  result_d = prod_uu[2*`XLEN-1:`XLEN];
            // zero divisor keeps the all-ones quotient
            m_ext_pkg::ALU_M_OPS_DIV:
                result_d = ((sign1_q ^ sign2_q) && (opr2_q != '0)) ? -div_quo : div_quo;
            m_ext_pkg::ALU_M_OPS_DIVU:   result_d = div_quo;
            m_ext_pkg::ALU_M_OPS_REM:    result_d = sign1_q ? -div_rem : div_rem;
            m_ext_pkg::ALU_M_OPS_REMU:   result_d = div_rem;
            default:                     result_d = '0;
        endcase
    end

    assign mul2fwd_o.mul_req      = held;
    assign mul2fwd_o.mul_ack      = ack_q;
    assign mul2wrb_o.alu_m_result = result_q;

    divider divider_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .start_i (div_start),
        .abort_i (fwd2mul_flush_i),  // flush drops the running divide
        .opr1_i  (opr1_q),
        .opr2_i  (opr2_q),
        .busy_o  (div_busy),
        .done_o  (div_done),
        .quo_o   (div_quo),
        .rem_o   (div_rem)
    );

endmodule

/* design/pipe_pkg.sv */
// Pipeline stage interface structs
`include "m_ext_macros.svh"

package pipe_pkg;

    // execute stage request
    typedef struct packed {
        m_ext_pkg::alu_m_op_u alu_m_ops;
        logic [`XLEN-1:0]     alu_operand_1;
        logic [`XLEN-1:0]     alu_operand_2;
    } type_exe2mul_s;

    // hazard unit controls, flush wins over stall
    typedef struct packed {
        logic stall;
        logic flush;
    } type_fwd2mul_s;

    // status back to the hazard unit
    typedef struct packed {
        logic mul_req;  // op held in the unit
        logic mul_ack;  // result valid
    } type_mul2fwd_s;

    // writeback payload
    typedef struct packed {
        logic [`XLEN-1:0] alu_m_result;
    } type_mul2wrb_s;

endpackage

/* flist.f */
+incdir+design
design/m_ext_pkg.sv
design/pipe_pkg.sv
design/divider.sv
design/muldiv.sv
design/m_ext_unit.sv
bench/m_ext_unit_sva.sv
bench/tb_m_ext_unit.sv
